//--- dma_bus_pkg.sv
`default_nettype none

package dma_bus_pkg;

	// cpu side register window
	typedef logic [2:0] reg_addr_t;
	typedef logic [15:0] cpu_word_t;

	// controller access / sector count
	localparam reg_addr_t ADDR_CTRL = 3'd2;
	// mode on write, dma status on read
	localparam reg_addr_t ADDR_MODE = 3'd3;
	localparam reg_addr_t ADDR_BASE_HI = 3'd4;
	localparam reg_addr_t ADDR_BASE_MID = 3'd5;
	localparam reg_addr_t ADDR_BASE_LO = 3'd6;

	// mode bits 4..1, msb first
	typedef struct packed {
		logic sel_count;
		logic sel_acsi;
		// upper bit doubles as acsi further-byte flag
		logic [1:0] reg_sel;
	} dma_mode_t;

	// one cpu bus cycle
	typedef struct packed {
		logic sel;
		logic rw;
		logic lds;
		reg_addr_t addr;
		cpu_word_t din;
	} cpu_req_t;

	// decoded floppy register write
	typedef struct packed {
		logic valid;
		logic [1:0] reg_sel;
		logic [7:0] data;
	} fdc_wr_t;

	// decoded acsi byte write
	typedef struct packed {
		logic valid;
		logic first;
		logic [7:0] data;
	} acsi_wr_t;

endpackage

`default_nettype wire

//--- dma_status_pkg.sv
`default_nettype none

package dma_status_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [7:0] track_t;
	typedef logic [15:0] motor_count_t;

	// motor keeps spinning this many cycles after a command
	localparam motor_count_t MOTOR_TIME = 16'hffff;
	// parameter bytes after the acsi command byte
	localparam int ACSI_PARMS = 5;

	// floppy busy sequencer
	typedef enum logic [1:0] {
		FDC_IDLE = 2'd0,
		FDC_FINISH = 2'd1,
		FDC_COUNT = 2'd2,
		FDC_WAIT_IO = 2'd3
	} fdc_busy_e;

	// floppy controller state as seen by the register file
	typedef struct packed {
		byte_t cmd;
		track_t track;
		byte_t sector;
		byte_t data;
		byte_t status_byte;
		logic busy;
		logic irq;
	} fdc_status_t;

	// acsi command as collected so far
	typedef struct packed {
		logic [2:0] target;
		logic [4:0] cmd;
		byte_t [ACSI_PARMS-1:0] parms;
		logic busy;
		logic irq;
	} acsi_status_t;

endpackage

`default_nettype wire

//--- fdc_emulator.sv
`timescale 1ns/1ps
`default_nettype none

module fdc_emulator import dma_bus_pkg::*, dma_status_pkg::*; (
	input logic clk,
	input logic reset,
	input fdc_wr_t wr,
	input logic status_rd,
	input logic io_done,
	input logic wr_prot,
	output fdc_status_t fdc
);

	byte_t cmd;
	track_t track;
	byte_t sector;
	byte_t data;
	// 1 = stepping towards higher tracks
	logic step_dir;
	motor_count_t motor;
	fdc_busy_e busy;
	logic irq;

	logic track0;
	logic motor_on;

	assign track0 = (track == 8'd0);
	assign motor_on = (motor != 16'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			cmd <= 8'd0;
			track <= 8'd0;
			sector <= 8'd0;
			data <= 8'd0;
			step_dir <= 1'b0;
			motor <= 16'd0;
			busy <= FDC_IDLE;
			irq <= 1'b0;
		end else begin
			// busy phase runs down unless parked for the io controller
			case (busy)
				FDC_COUNT: busy <= FDC_FINISH;
				FDC_FINISH: begin
					irq <= 1'b1;
					busy <= FDC_IDLE;
				end
				FDC_WAIT_IO: begin
					if (io_done)
						busy <= FDC_FINISH;
				end
				default: busy <= FDC_IDLE;
			endcase

			if (motor_on)
				motor <= motor - 16'd1;

			// status read acks the irq
			if (status_rd)
				irq <= 1'b0;

			if (wr.valid) begin
				case (wr.reg_sel)
					2'd0: begin
						cmd <= wr.data;
						// new command restarts the sequence
						busy <= FDC_COUNT;
						// type I and type II spin up the motor
						if (!wr.data[7] || (wr.data[7:6] == 2'b10))
							motor <= MOTOR_TIME;
						casez (wr.data[7:4])
							// restore
							4'b0000: track <= 8'd0;
							// seek to the track in the data register
							4'b0001: track <= data;
							// step in last direction
							4'b0011: track <= step_dir ? track + 8'd1 : track - 8'd1;
							4'b0101: begin
								step_dir <= 1'b1;
								track <= track + 8'd1;
							end
							4'b0111: begin
								step_dir <= 1'b0;
								track <= track - 8'd1;
							end
							// read sector, io controller does the work
							4'b100?: busy <= FDC_WAIT_IO;
							// write sector unless disk is protected
							4'b101?: begin
								if (!wr_prot)
									busy <= FDC_WAIT_IO;
							end
							// force interrupt, straight to the end
							4'b1101: busy <= FDC_FINISH;
							default: ;
						endcase
					end
					2'd1: track <= wr.data;
					2'd2: sector <= wr.data;
					default: data <= wr.data;
				endcase
			end
		end
	end

	// track0 only reported for type I commands
	assign fdc.status_byte = {motor_on, wr_prot, 3'b000, !cmd[7] && track0, 1'b0,
		busy != FDC_IDLE};
	assign fdc.cmd = cmd;
	assign fdc.track = track;
	assign fdc.sector = sector;
	assign fdc.data = data;
	assign fdc.busy = (busy != FDC_IDLE);
	assign fdc.irq = irq;

endmodule

`default_nettype wire

//--- acsi_collector.sv
`timescale 1ns/1ps
`default_nettype none

module acsi_collector import dma_bus_pkg::*, dma_status_pkg::*; (
	input logic clk,
	input logic reset,
	input acsi_wr_t wr,
	input logic status_rd,
	input logic io_done,
	input byte_t acsi_enable,
	output acsi_status_t acsi
);

	logic [2:0] target;
	logic [4:0] cmd;
	// index of next parameter byte
	logic [2:0] byte_cnt;
	byte_t [ACSI_PARMS-1:0] parms;
	logic busy;
	logic irq;

	always_ff @(posedge clk) begin
		if (reset) begin
			target <= 3'd0;
			cmd <= 5'd0;
			byte_cnt <= 3'd0;
			parms <= '0;
			busy <= 1'b0;
			irq <= 1'b0;
		end else begin
			// io controller finished the transfer
			if (io_done && busy) begin
				busy <= 1'b0;
				irq <= 1'b1;
			end

			// any status access acks, a new byte below may set it again
			if (status_rd)
				irq <= 1'b0;

			if (wr.valid) begin
				if (wr.first) begin
					// command byte, target in top three bits
					target <= wr.data[7:5];
					cmd <= wr.data[4:0];
					byte_cnt <= 3'd0;
					if (acsi_enable[wr.data[7:5]])
						irq <= 1'b1;
				end else begin
					if (byte_cnt < 3'(ACSI_PARMS))
						parms[byte_cnt] <= wr.data;
					byte_cnt <= byte_cnt + 3'd1;
					// disabled targets never answer
					if (acsi_enable[target]) begin
						// ack all but the last parameter ourselves
						if (byte_cnt < 3'(ACSI_PARMS - 1))
							irq <= 1'b1;
						else
							busy <= 1'b1;
					end
				end
			end
		end
	end

	assign acsi.target = target;
	assign acsi.cmd = cmd;
	assign acsi.parms = parms;
	assign acsi.busy = busy;
	assign acsi.irq = irq;

endmodule

`default_nettype wire

//--- dma_register_file.sv
`timescale 1ns/1ps
`default_nettype none

module dma_register_file import dma_bus_pkg::*, dma_status_pkg::*; (
	input logic clk,
	input logic reset,
	input cpu_req_t req,
	input logic dio_ack,
	input logic [4:0] dio_idx,
	input logic drv_side,
	input logic [1:0] drv_sel,
	input fdc_status_t fdc,
	input acsi_status_t acsi,
	output fdc_wr_t fdc_wr,
	output acsi_wr_t acsi_wr,
	output logic fdc_status_rd,
	output logic acsi_status_rd,
	output logic io_done,
	output cpu_word_t dout,
	output logic irq,
	output byte_t dio_data
);

	dma_mode_t mode;
	// index 2 is the high byte
	byte_t [2:0] base;
	byte_t scnt;
	logic [1:0] ack_sync;

	logic cpu_wr;
	logic cpu_rd;
	logic ctrl_wr;
	logic ctrl_sel;

	assign cpu_wr = req.sel && !req.rw;
	assign cpu_rd = req.sel && req.rw;
	// byte write to the controller access register
	assign ctrl_wr = cpu_wr && !req.lds && (req.addr == ADDR_CTRL);
	// controller access only when sector count is not selected
	assign ctrl_sel = (req.addr == ADDR_CTRL) && !mode.sel_count;

	assign fdc_wr.valid = ctrl_wr && !mode.sel_count && !mode.sel_acsi;
	assign fdc_wr.reg_sel = mode.reg_sel;
	assign fdc_wr.data = req.din[7:0];

	assign acsi_wr.valid = ctrl_wr && !mode.sel_count && mode.sel_acsi;
	assign acsi_wr.first = !mode.reg_sel[1];
	assign acsi_wr.data = req.din[7:0];

	assign fdc_status_rd = cpu_rd && ctrl_sel && !mode.sel_acsi && (mode.reg_sel == 2'd0);
	// reads and writes both count as status access
	assign acsi_status_rd = req.sel && ctrl_sel && mode.sel_acsi;

	// rising edge of the synchronized ack
	assign io_done = ack_sync[0] && !ack_sync[1];

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= '0;
			base <= '0;
			scnt <= 8'd0;
			ack_sync <= 2'b00;
		end else begin
			ack_sync <= {ack_sync[0], dio_ack};
			// all sectors moved
			if (io_done)
				scnt <= 8'd0;
			if (cpu_wr) begin
				// mode takes the whole word, lds not checked
				if (req.addr == ADDR_MODE)
					mode <= req.din[4:1];
				if (ctrl_wr && mode.sel_count)
					scnt <= req.din[7:0];
				if (!req.lds) begin
					case (req.addr)
						ADDR_BASE_HI: base[2] <= req.din[7:0];
						ADDR_BASE_MID: base[1] <= req.din[7:0];
						ADDR_BASE_LO: base[0] <= req.din[7:0];
						default: ;
					endcase
				end
			end
		end
	end

	assign irq = fdc.irq || acsi.irq;

	// cpu read mux
	always_comb begin
		dout = 16'h0000;
		if (cpu_rd) begin
			case (req.addr)
				ADDR_CTRL: begin
					if (mode.sel_count)
						dout = {8'h00, scnt};
					else if (mode.sel_acsi)
						dout = {8'h00, 4'b0000, acsi.busy, 3'b000};
					else begin
						case (mode.reg_sel)
							2'd0: dout = {8'h00, fdc.status_byte};
							2'd1: dout = {8'h00, fdc.track};
							2'd2: dout = {8'h00, fdc.sector};
							default: dout = {8'h00, fdc.data};
						endcase
					end
				end
				// dma status, bit 0 is dma ok
				ADDR_MODE: dout = {14'd0, scnt != 8'd0, 1'b1};
				ADDR_BASE_HI: dout = {8'h00, base[2]};
				ADDR_BASE_MID: dout = {8'h00, base[1]};
				ADDR_BASE_LO: dout = {8'h00, base[0]};
				default: dout = 16'h0000;
			endcase
		end
	end

	// status port towards the io controller
	always_comb begin
		case (dio_idx)
			5'd0: dio_data = base[2];
			5'd1: dio_data = base[1];
			5'd2: dio_data = base[0];
			5'd3: dio_data = scnt;
			5'd4: dio_data = fdc.cmd;
			5'd5: dio_data = fdc.track;
			5'd6: dio_data = fdc.sector;
			5'd7: dio_data = fdc.data;
			5'd8: dio_data = {3'b000, acsi.busy, drv_sel, drv_side, fdc.busy};
			5'd9: dio_data = {acsi.target, acsi.cmd};
			5'd10: dio_data = acsi.parms[0];
			5'd11: dio_data = acsi.parms[1];
			5'd12: dio_data = acsi.parms[2];
			5'd13: dio_data = acsi.parms[3];
			5'd14: dio_data = acsi.parms[4];
			default: dio_data = 8'h00;
		endcase
	end

endmodule

`default_nettype wire

//--- dma_top.sv
`timescale 1ns/1ps
`default_nettype none

module dma_top import dma_bus_pkg::*, dma_status_pkg::*; (
	input logic clk,
	input logic reset,
	// cpu register port
	input logic [15:0] din,
	input logic sel,
	input logic [2:0] addr,
	input logic lds,
	input logic rw,
	output logic [15:0] dout,
	// to the mfp
	output logic irq,
	// system config
	input logic fdc_wr_prot,
	input logic [7:0] acsi_enable,
	// io controller status port
	input logic [4:0] dio_idx,
	output logic [7:0] dio_data,
	input logic dio_ack,
	// drive select from the psg
	input logic drv_side,
	input logic [1:0] drv_sel
);

	cpu_req_t req;
	fdc_wr_t fdc_wr;
	acsi_wr_t acsi_wr;
	fdc_status_t fdc;
	acsi_status_t acsi;
	logic fdc_status_rd;
	logic acsi_status_rd;
	logic io_done;

	assign req = '{sel: sel, rw: rw, lds: lds, addr: addr, din: din};

	dma_register_file u_regs (
		.clk(clk), .reset(reset), .req(req), .dio_ack(dio_ack), .dio_idx(dio_idx),
		.drv_side(drv_side), .drv_sel(drv_sel), .fdc(fdc), .acsi(acsi),
		.fdc_wr(fdc_wr), .acsi_wr(acsi_wr), .fdc_status_rd(fdc_status_rd),
		.acsi_status_rd(acsi_status_rd), .io_done(io_done), .dout(dout),
		.irq(irq), .dio_data(dio_data)
	);

	fdc_emulator u_fdc (
		.clk(clk), .reset(reset), .wr(fdc_wr), .status_rd(fdc_status_rd),
		.io_done(io_done), .wr_prot(fdc_wr_prot), .fdc(fdc)
	);

	acsi_collector u_acsi (
		.clk(clk), .reset(reset), .wr(acsi_wr), .status_rd(acsi_status_rd),
		.io_done(io_done), .acsi_enable(acsi_enable), .acsi(acsi)
	);

endmodule

`default_nettype wire

//--- tb_dma.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma import dma_bus_pkg::*;;

	localparam logic [31:0] SEED = 32'hbc34ad3d;
	// iterations per test
	localparam int N_REG = 20;
	localparam int N_TYPE1 = 40;
	localparam int N_SECT = 30;
	localparam int N_ACSI = 30;
	localparam int N_SWEEP = 4;
	// worst case cycles of one iteration, reset and margin on top
	localparam int CYCLE_LIMIT = 16 + N_REG * 30 + N_TYPE1 * 30 + N_SECT * 40
		+ N_ACSI * 60 + 60 + N_SWEEP * 40 + 200;

	logic clk;
	logic reset;
	logic [15:0] din;
	logic sel;
	logic [2:0] addr;
	logic lds;
	logic rw;
	logic [15:0] dout;
	logic irq;
	logic fdc_wr_prot;
	logic [7:0] acsi_enable;
	logic [4:0] dio_idx;
	logic [7:0] dio_data;
	logic dio_ack;
	logic drv_side;
	logic [1:0] drv_sel;

	logic [31:0] lfsr;
	int cycles;
	int checks;
	int errors;
	int mark_checks;
	int mark_errors;
	int tests;

	// reference model state
	logic [7:0] m_base [3];
	logic [7:0] m_scnt;
	logic [7:0] m_cmd;
	logic [7:0] m_track;
	logic [7:0] m_sector;
	logic [7:0] m_data;
	// 1 = step towards higher tracks
	logic m_dir;
	logic [2:0] m_target;
	logic [4:0] m_acmd;
	logic [7:0] m_parms [5];
	logic m_abusy;

	dma_top dut (
		.clk(clk), .reset(reset), .din(din), .sel(sel), .addr(addr), .lds(lds), .rw(rw),
		.dout(dout), .irq(irq), .fdc_wr_prot(fdc_wr_prot), .acsi_enable(acsi_enable),
		.dio_idx(dio_idx), .dio_data(dio_data), .dio_ack(dio_ack), .drv_side(drv_side),
		.drv_sel(drv_sel)
	);

	always #5 clk = ~clk;

	// run limit
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout, run stopped after %0d cycles", cycles);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// galois lfsr, taps x^32+x^22+x^2+x+1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = 32'd0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// status port as the model expects it, fdc assumed idle
	function automatic logic [7:0] model_dio(input int idx);
		if (idx <= 2)
			return m_base[idx];
		case (idx)
			3: return m_scnt;
			4: return m_cmd;
			5: return m_track;
			6: return m_sector;
			7: return m_data;
			8: return {3'b000, m_abusy, drv_sel, drv_side, 1'b0};
			9: return {m_target, m_acmd};
			10, 11, 12, 13, 14: return m_parms[idx - 10];
			default: return 8'h00;
		endcase
	endfunction

	task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		assert (act === exp) else begin
			$display("ERR %s expected %h got %h", name, exp, act);
			errors++;
		end
	endtask

	// next edge, then the input drive point
	task automatic tick;
		@(posedge clk);
		#1;
	endtask

	// one bus cycle, sampled at the second edge
	task automatic cpu_access(input logic is_read, input logic [2:0] a, input logic [15:0] d,
		output logic [15:0] q);
		tick;
		sel = 1'b1;
		rw = is_read;
		addr = a;
		din = d;
		#1;
		q = dout;
		// read data only while reading
		if (!is_read)
			check("dout on write", 16'h0000, q);
		tick;
		sel = 1'b0;
		rw = 1'b1;
		din = 16'h0000;
	endtask

	task automatic cpu_write(input logic [2:0] a, input logic [15:0] d);
		logic [15:0] q;
		cpu_access(1'b0, a, d, q);
	endtask

	task automatic cpu_read(input logic [2:0] a, output logic [15:0] q);
		cpu_access(1'b1, a, 16'h0000, q);
	endtask

	task automatic set_mode(input logic sc, input logic sa, input logic [1:0] rs);
		cpu_write(ADDR_MODE, {11'd0, sc, sa, rs, 1'b0});
	endtask

	task automatic peek_dio(input logic [4:0] idx, output logic [7:0] v);
		tick;
		dio_idx = idx;
		#1;
		v = dio_data;
	endtask

	// io controller completion is a few edges after dio_ack
	task automatic wait_irq;
		int n;
		n = 0;
		while (!irq && n < 8) begin
			tick;
			n++;
		end
		checks++;
		assert (irq && n <= 4) else begin
			$display("irq did not rise within 4 cycles after dio_ack");
			errors++;
		end
	endtask

	// command whose irq rises irq_edge edges after the write
	task automatic fdc_command_timed(input logic [7:0] c, input int irq_edge);
		cpu_write(ADDR_CTRL, {8'h00, c});
		dio_idx = 5'd8;
		#1;
		check("irq", 16'h0000, 16'(irq));
		check("fdc busy", 16'h0001, 16'(dio_data[0]));
		for (int e = 1; e <= irq_edge; e++) begin
			tick;
			dio_idx = 5'd8;
			#1;
			check("irq", 16'(e == irq_edge), 16'(irq));
			check("fdc busy", 16'(e != irq_edge), 16'(dio_data[0]));
		end
	endtask

	// motor always running here, track0 only for type I
	task automatic fdc_status_check;
		logic [15:0] q;
		cpu_read(ADDR_CTRL, q);
		check("dout fdc status", {8'h00, 1'b1, fdc_wr_prot, 3'b000,
			!m_cmd[7] && (m_track == 8'd0), 2'b00}, q);
		check("irq", 16'h0000, 16'(irq));
	endtask

	// auto ack of an acsi byte
	task automatic acsi_ack(input logic en);
		logic [15:0] q;
		check("irq", 16'(en), 16'(irq));
		if (en) begin
			cpu_read(ADDR_CTRL, q);
			check("dout acsi status", 16'h0000, q);
			check("irq", 16'h0000, 16'(irq));
		end
	endtask

	task automatic acsi_command(input logic release_io);
		logic en;
		logic [15:0] q;
		acsi_enable = 8'(take_bits(8));
		m_target = 3'(take_bits(3));
		m_acmd = 5'(take_bits(5));
		en = acsi_enable[m_target];
		set_mode(1'b0, 1'b1, 2'd0);
		cpu_write(ADDR_CTRL, {8'h00, m_target, m_acmd});
		acsi_ack(en);
		// further bytes
		set_mode(1'b0, 1'b1, 2'd2);
		for (int k = 0; k < 5; k++) begin
			m_parms[k] = 8'(take_bits(8));
			cpu_write(ADDR_CTRL, {8'h00, m_parms[k]});
			if (k < 4) begin
				acsi_ack(en);
			end else begin
				check("irq", 16'h0000, 16'(irq));
				m_abusy = en;
				cpu_read(ADDR_CTRL, q);
				check("dout acsi busy", 16'({m_abusy, 3'b000}), q);
			end
		end
		if (release_io && en) begin
			dio_ack = 1'b1;
			wait_irq;
			m_abusy = 1'b0;
			m_scnt = 8'h00;
			peek_dio(5'd8, q[7:0]);
			check("dio acsi busy", 16'h0000, 16'(q[4]));
			dio_ack = 1'b0;
			cpu_read(ADDR_CTRL, q);
			check("dout acsi status", 16'h0000, q);
			check("irq", 16'h0000, 16'(irq));
		end
	endtask

	task automatic reg_test;
		logic [15:0] q;
		logic [7:0] v;
		for (int it = 0; it < N_REG; it++) begin
			for (int b = 0; b < 3; b++) begin
				m_base[b] = 8'(take_bits(8));
				cpu_write(ADDR_BASE_HI + 3'(b), {8'(take_bits(8)), m_base[b]});
			end
			// base ignores writes with lds high, mode does not
			lds = 1'b1;
			cpu_write(ADDR_BASE_LO, {8'h00, ~m_base[2]});
			set_mode(1'b1, 1'(take_bits(1)), 2'(take_bits(2)));
			lds = 1'b0;
			m_scnt = 8'(take_bits(8));
			cpu_write(ADDR_CTRL, {8'h00, m_scnt});
			cpu_read(ADDR_CTRL, q);
			check("dout scnt", 16'(m_scnt), q);
			cpu_read(ADDR_MODE, q);
			check("dout dma status", {14'd0, m_scnt != 8'd0, 1'b1}, q);
			for (int b = 0; b < 3; b++) begin
				cpu_read(ADDR_BASE_HI + 3'(b), q);
				check("dout base", 16'(m_base[b]), q);
			end
			for (int i = 0; i < 4; i++) begin
				peek_dio(5'(i), v);
				check("dio_data", 16'(model_dio(i)), 16'(v));
			end
		end
	endtask

	task automatic type1_test;
		int op;
		logic [3:0] low;
		logic [15:0] q;
		logic [7:0] v;
		for (int it = 0; it < N_TYPE1; it++) begin
			fdc_wr_prot = 1'(take_bits(1));
			op = int'(take_bits(3)) % 5;
			low = 4'(take_bits(4));
			if (op == 1) begin
				// seek target goes through the data register
				set_mode(1'b0, 1'b0, 2'd3);
				m_data = 8'(take_bits(8));
				cpu_write(ADDR_CTRL, {8'h00, m_data});
			end
			set_mode(1'b0, 1'b0, 2'd0);
			case (op)
				0: begin
					m_cmd = {4'b0000, low};
					m_track = 8'd0;
				end
				1: begin
					m_cmd = {4'b0001, low};
					m_track = m_data;
				end
				2: begin
					m_cmd = {4'b0011, low};
					m_track = m_dir ? m_track + 8'd1 : m_track - 8'd1;
				end
				3: begin
					m_cmd = {4'b0101, low};
					m_dir = 1'b1;
					m_track = m_track + 8'd1;
				end
				default: begin
					m_cmd = {4'b0111, low};
					m_dir = 1'b0;
					m_track = m_track - 8'd1;
				end
			endcase
			fdc_command_timed(m_cmd, 2);
			fdc_status_check;
			set_mode(1'b0, 1'b0, 2'd1);
			cpu_read(ADDR_CTRL, q);
			check("dout track", 16'(m_track), q);
			peek_dio(5'd5, v);
			check("dio track", 16'(m_track), 16'(v));
		end
	endtask

	task automatic sector_test;
		logic is_write;
		int d;
		logic [7:0] v;
		for (int it = 0; it < N_SECT; it++) begin
			fdc_wr_prot = 1'(take_bits(1));
			is_write = 1'(take_bits(1));
			set_mode(1'b1, 1'b0, 2'd0);
			m_scnt = 8'(take_bits(8)) | 8'h01;
			cpu_write(ADDR_CTRL, {8'h00, m_scnt});
			set_mode(1'b0, 1'b0, 2'd0);
			m_cmd = {2'b10, is_write, 5'(take_bits(5))};
			if (is_write && fdc_wr_prot) begin
				fdc_command_timed(m_cmd, 2);
			end else begin
				cpu_write(ADDR_CTRL, {8'h00, m_cmd});
				d = 2 + int'(take_bits(3));
				// parked until the io controller answers
				for (int i = 0; i < d; i++) begin
					peek_dio(5'd8, v);
					check("irq", 16'h0000, 16'(irq));
					check("fdc busy", 16'h0001, 16'(v[0]));
				end
				if (take_bits(1) == 32'd1) begin
					m_cmd = {4'b1101, 4'(take_bits(4))};
					fdc_command_timed(m_cmd, 1);
				end else begin
					dio_ack = 1'b1;
					wait_irq;
					m_scnt = 8'h00;
					peek_dio(5'd8, v);
					check("fdc busy", 16'h0000, 16'(v[0]));
					peek_dio(5'd3, v);
					check("dio scnt", 16'(m_scnt), 16'(v));
					dio_ack = 1'b0;
				end
			end
			fdc_status_check;
		end
	endtask

	task automatic status_port_test;
		logic [7:0] v;
		acsi_command(1'b0);
		set_mode(1'b0, 1'b0, 2'd2);
		m_sector = 8'(take_bits(8));
		cpu_write(ADDR_CTRL, {8'h00, m_sector});
		for (int s = 0; s < N_SWEEP; s++) begin
			drv_side = 1'(take_bits(1));
			drv_sel = 2'(take_bits(2));
			for (int i = 0; i < 32; i++) begin
				peek_dio(5'(i), v);
				check("dio_data", 16'(model_dio(i)), 16'(v));
			end
		end
	endtask

	task automatic report_test(input string name);
		$display("%s: %0d checks, %0d errors", name, checks - mark_checks,
			errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
		tests++;
	endtask

	initial begin
		lfsr = SEED;
		cycles = 0;
		checks = 0;
		errors = 0;
		mark_checks = 0;
		mark_errors = 0;
		tests = 0;
		clk = 1'b0;
		reset = 1'b1;
		din = 16'h0000;
		sel = 1'b0;
		addr = 3'd0;
		lds = 1'b0;
		rw = 1'b1;
		fdc_wr_prot = 1'b0;
		acsi_enable = 8'h00;
		dio_idx = 5'd0;
		dio_ack = 1'b0;
		drv_side = 1'b0;
		drv_sel = 2'd0;
		// model matches the reset state
		foreach (m_base[i])
			m_base[i] = 8'h00;
		foreach (m_parms[i])
			m_parms[i] = 8'h00;
		m_scnt = 8'h00;
		m_cmd = 8'h00;
		m_track = 8'h00;
		m_sector = 8'h00;
		m_data = 8'h00;
		m_dir = 1'b0;
		m_target = 3'd0;
		m_acmd = 5'd0;
		m_abusy = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;
		check("irq after reset", 16'h0000, 16'(irq));
		check("dout after reset", 16'h0000, dout);
		check("dio_data after reset", 16'h0000, 16'(dio_data));
		reg_test;
		report_test("register readback");
		type1_test;
		report_test("type I commands");
		sector_test;
		report_test("sector commands");
		for (int it = 0; it < N_ACSI; it++)
			acsi_command(1'b1);
		report_test("acsi commands");
		status_port_test;
		report_test("status port");
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
dma_bus_pkg.sv
dma_status_pkg.sv
fdc_emulator.sv
acsi_collector.sv
dma_register_file.sv
dma_top.sv
tb_dma.sv

//--- run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_dma -f compile.f -o tb_dma

./obj_dir/tb_dma | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
